// ==== filelist.f ====
+incdir+src
src/processorci_pkg.sv
src/obi_port.sv
src/wb_arbiter.sv
src/processorci_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_top
RTL_TOP   ?= processorci_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

RTL_SRCS = src/processorci_pkg.sv src/obi_port.sv src/wb_arbiter.sv src/processorci_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+src --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(RTL_SRCS) tb/tb_top.sv tb/tb_checker.sv
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TXN          = 200;
    localparam int MAX_ACK_DELAY  = 3;
    localparam int MEM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = N_TXN * 2 * (MAX_ACK_DELAY + 6);
    localparam logic [31:0] TAPS  = 32'h8020_0003;

    logic                      sys_clk;
    logic                      rst_n;
    logic                      req_v [2];
    processorci_pkg::bus_req_t req_data_v [2];
    logic                      instr_gnt;
    logic                      instr_rvalid;
    processorci_pkg::data_t    instr_rdata;
    logic                      data_gnt;
    logic                      data_rvalid;
    processorci_pkg::data_t    data_rdata;
    logic                      wb_cyc;
    logic                      wb_stb;
    processorci_pkg::bus_req_t wb_req;
    logic                      wb_ack;
    processorci_pkg::data_t    wb_rdata;

    processorci_pkg::data_t    mem [MEM_WORDS];
    logic [31:0]               lfsr;
    logic                      gnt_seen [2];
    int                        gap [2];
    int                        launched [2];
    int                        ack_wait;
    logic                      in_xfer;
    int                        val_errs;
    int                        proto_errs;
    int                        instr_answered;
    int                        data_answered;

    processorci_top UUT (
        .sys_clk          (sys_clk),
        .rst_n_i          (rst_n),
        .instr_req_i      (req_v[0]),
        .instr_req_data_i (req_data_v[0]),
        .instr_gnt_o      (instr_gnt),
        .instr_rvalid_o   (instr_rvalid),
        .instr_rdata_o    (instr_rdata),
        .data_req_i       (req_v[1]),
        .data_req_data_i  (req_data_v[1]),
        .data_gnt_o       (data_gnt),
        .data_rvalid_o    (data_rvalid),
        .data_rdata_o     (data_rdata),
        .wb_cyc_o         (wb_cyc),
        .wb_stb_o         (wb_stb),
        .wb_req_o         (wb_req),
        .wb_ack_i         (wb_ack),
        .wb_rdata_i       (wb_rdata)
    );

    tb_checker u_checker (
        .clk_i            (sys_clk),
        .rst_n_i          (rst_n),
        .instr_req_i      (req_v[0]),
        .instr_req_data_i (req_data_v[0]),
        .instr_gnt_i      (instr_gnt),
        .instr_rvalid_i   (instr_rvalid),
        .instr_rdata_i    (instr_rdata),
        .data_req_i       (req_v[1]),
        .data_req_data_i  (req_data_v[1]),
        .data_gnt_i       (data_gnt),
        .data_rvalid_i    (data_rvalid),
        .data_rdata_i     (data_rdata),
        .wb_cyc_i         (wb_cyc),
        .wb_stb_i         (wb_stb),
        .wb_req_i         (wb_req),
        .wb_ack_i         (wb_ack),
        .val_errs_o       (val_errs),
        .proto_errs_o     (proto_errs),
        .instr_answered_o (instr_answered),
        .data_answered_o  (data_answered)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] get_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic processorci_pkg::data_t initial_word(input int idx);
        logic [31:0] a;
        a = 32'(idx) << 2;
        return (a * 32'h9e37_79b1) ^ 32'h1357_2468;
    endfunction

    // Wishbone memory, acks after a random wait
    task automatic serve_bus();
        int idx;
        wb_ack = 1'b0;
        if (wb_cyc) begin
            if (!in_xfer) begin
                in_xfer  = 1'b1;
                ack_wait = int'(get_bits(2)) % (MAX_ACK_DELAY + 1);
            end
            if (ack_wait == 0) begin
                idx      = int'(wb_req.addr[7:2]);
                wb_rdata = mem[idx];
                if (wb_req.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req.sel[b]) begin
                            mem[idx][8*b +: 8] = wb_req.wdata[8*b +: 8];
                        end
                    end
                end
                wb_ack  = 1'b1;
                in_xfer = 1'b0;
            end else begin
                ack_wait--;
            end
        end
    endtask

    // One OBI master, port 0 fetches and port 1 loads or stores
    task automatic drive_port(input int p);
        logic [31:0] r;
        if (req_v[p] && gnt_seen[p]) begin
            req_v[p] = 1'b0;
            gap[p]   = int'(get_bits(2));
        end
        if (!req_v[p]) begin
            if (gap[p] > 0) begin
                gap[p]--;
            end else if (launched[p] < N_TXN) begin
                r = get_bits(6);
                req_data_v[p].addr = {24'h0, r[5:0], 2'b00};
                if (p == 1) begin
                    r = get_bits(1);
                    req_data_v[p].we = r[0];
                    r = get_bits(4);
                    req_data_v[p].sel = req_data_v[p].we ? r[3:0] : 4'hf;
                end else begin
                    req_data_v[p].we  = 1'b0;
                    req_data_v[p].sel = 4'hf;
                end
                req_data_v[p].wdata = get_bits(32);
                req_v[p] = 1'b1;
                launched[p]++;
            end
        end
    endtask

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    initial begin
        rst_n    = 1'b0;
        lfsr     = 32'h56a3;
        wb_ack   = 1'b0;
        wb_rdata = '0;
        in_xfer  = 1'b0;
        ack_wait = 0;
        for (int p = 0; p < 2; p++) begin
            req_v[p]      = 1'b0;
            req_data_v[p] = '0;
            gnt_seen[p]   = 1'b0;
            gap[p]        = 0;
            launched[p]   = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = initial_word(i);
        end
        repeat (10) @(posedge sys_clk);
        #1 rst_n = 1'b1;
        forever begin
            @(negedge sys_clk);
            gnt_seen[0] = instr_gnt;     // Value the next edge will see
            gnt_seen[1] = data_gnt;
            @(posedge sys_clk);
            #1;
            serve_bus();
            drive_port(0);
            drive_port(1);
        end
    end

    initial begin
        @(posedge rst_n);
        while (instr_answered < N_TXN || data_answered < N_TXN) begin
            @(posedge sys_clk);
        end
        repeat (5) @(posedge sys_clk);
        $display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES + 10) @(posedge sys_clk);
        $display("Timeout: not all requests were answered in %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== tb/tb_checker.sv ====
module tb_checker (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      instr_req_i,
    input  processorci_pkg::bus_req_t instr_req_data_i,
    input  logic                      instr_gnt_i,
    input  logic                      instr_rvalid_i,
    input  processorci_pkg::data_t    instr_rdata_i,
    input  logic                      data_req_i,
    input  processorci_pkg::bus_req_t data_req_data_i,
    input  logic                      data_gnt_i,
    input  logic                      data_rvalid_i,
    input  processorci_pkg::data_t    data_rdata_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  processorci_pkg::bus_req_t wb_req_i,
    input  logic                      wb_ack_i,
    output int                        val_errs_o,
    output int                        proto_errs_o,
    output int                        instr_answered_o,
    output int                        data_answered_o
);
    timeunit 1ns;
    timeprecision 1ps;

    processorci_pkg::data_t    shadow [64];     // Reference memory over the 64-word window
    processorci_pkg::bus_req_t exp_req [2];
    processorci_pkg::data_t    exp_rdata [2];
    logic                      exp_valid [2];   // Granted and still waiting for rvalid
    logic                      issued [2];      // Already seen on Wishbone
    logic                      acked [2];
    int                        grant_cyc [2];
    int                        ack_cyc [2];
    int                        answered [2];
    int                        owner;
    int                        last_served;
    int                        cyc_cnt;
    int                        val_errs;
    int                        proto_errs;
    logic                      prev_cyc;
    logic                      prev_ack;
    processorci_pkg::bus_req_t prev_req;

    // Power-up contents hashed from the byte address as in the bus memory
    function automatic processorci_pkg::data_t initial_word(input int idx);
        logic [31:0] a;
        a = 32'(idx) << 2;
        return (a * 32'h9e37_79b1) ^ 32'h1357_2468;
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            shadow[i] = initial_word(i);
        end
        val_errs   = 0;
        proto_errs = 0;
        cyc_cnt    = 0;
        answered[0] = 0;
        answered[1] = 0;
    end

    always @(negedge clk_i) begin : watch
        logic                      req [2];
        logic                      gnt [2];
        logic                      rv [2];
        processorci_pkg::data_t    rd [2];
        processorci_pkg::bus_req_t rq [2];
        logic                      cand [2];
        int                        idx;
        req[0] = instr_req_i;
        req[1] = data_req_i;
        gnt[0] = instr_gnt_i;
        gnt[1] = data_gnt_i;
        rv[0]  = instr_rvalid_i;
        rv[1]  = data_rvalid_i;
        rd[0]  = instr_rdata_i;
        rd[1]  = data_rdata_i;
        rq[0]  = instr_req_data_i;
        rq[1]  = data_req_data_i;
        cyc_cnt++;
        if (!rst_n_i) begin
            if (gnt[0] !== 1'b0 || gnt[1] !== 1'b0 || rv[0] !== 1'b0 || rv[1] !== 1'b0 ||
                wb_cyc_i !== 1'b0 || wb_stb_i !== 1'b0) begin
                $display("An output was active during reset at %0t", $time);
                proto_errs++;
            end
            for (int p = 0; p < 2; p++) begin
                exp_valid[p] = 1'b0;
                issued[p]    = 1'b0;
                acked[p]     = 1'b0;
            end
            owner       = -1;
            last_served = 1;        // First tie goes to instr
            prev_cyc    = 1'b0;
            prev_ack    = 1'b0;
        end else begin
            // Responses go first since a new grant may share the rvalid cycle
            for (int p = 0; p < 2; p++) begin
                if (rv[p]) begin
                    if (!exp_valid[p] || !acked[p]) begin
                        $display("Port %0d gave rvalid with no acknowledged request", p);
                        proto_errs++;
                    end else begin
                        if (cyc_cnt != ack_cyc[p] + 1) begin
                            $display("Port %0d rvalid did not follow its ack by one cycle", p);
                            proto_errs++;
                        end
                        if (!exp_req[p].we && rd[p] !== exp_rdata[p]) begin
                            $display("ERR %0t: port %0d read of %h gave %h, expected %h",
                                     $time, p, exp_req[p].addr, rd[p], exp_rdata[p]);
                            val_errs++;
                        end
                        exp_valid[p] = 1'b0;
                        answered[p]++;
                    end
                end
            end

            if (wb_cyc_i !== wb_stb_i) begin
                $display("Wishbone cyc and stb differ at %0t", $time);
                proto_errs++;
            end
            if (wb_cyc_i && prev_cyc && !prev_ack && wb_req_i !== prev_req) begin
                $display("Wishbone fields changed before ack at %0t", $time);
                proto_errs++;
            end
            if (wb_cyc_i && prev_ack) begin
                $display("Wishbone cyc stayed high right after ack at %0t", $time);
                proto_errs++;
            end

            if (wb_cyc_i && !prev_cyc) begin
                // Pending means granted at least two cycles before cyc rises
                for (int p = 0; p < 2; p++) begin
                    cand[p] = exp_valid[p] && !issued[p] && (cyc_cnt >= grant_cyc[p] + 2);
                end
                if (cand[0] && cand[1]) begin
                    owner = 1 - last_served;
                end else if (cand[0]) begin
                    owner = 0;
                end else if (cand[1]) begin
                    owner = 1;
                end else begin
                    owner = -1;
                    $display("Wishbone transfer started with no granted request");
                    proto_errs++;
                end
                if (owner >= 0) begin
                    issued[owner] = 1'b1;
                    if (owner == 0 && wb_req_i.we) begin
                        $display("ERR %0t: instruction transfer on Wishbone with we high",
                                 $time);
                        val_errs++;
                    end
                    if (wb_req_i !== exp_req[owner]) begin
                        $display("ERR %0t: Wishbone request %h, expected port %0d request %h",
                                 $time, wb_req_i, owner, exp_req[owner]);
                        val_errs++;
                    end
                end
            end

            if (wb_cyc_i && wb_ack_i && owner >= 0) begin
                idx = int'(wb_req_i.addr[7:2]);
                acked[owner]   = 1'b1;
                ack_cyc[owner] = cyc_cnt;
                last_served    = owner;
                if (wb_req_i.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req_i.sel[b]) begin
                            shadow[idx][8*b +: 8] = wb_req_i.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    exp_rdata[owner] = shadow[idx];
                end
            end
            prev_cyc = wb_cyc_i;
            prev_ack = wb_ack_i;
            prev_req = wb_req_i;

            for (int p = 0; p < 2; p++) begin
                if (req[p] && gnt[p]) begin
                    if (exp_valid[p]) begin
                        $display("Port %0d granted while a request was unanswered", p);
                        proto_errs++;
                    end
                    exp_valid[p] = 1'b1;
                    exp_req[p]   = rq[p];
                    issued[p]    = 1'b0;
                    acked[p]     = 1'b0;
                    grant_cyc[p] = cyc_cnt;
                end
            end
        end
    end

    assign val_errs_o       = val_errs;
    assign proto_errs_o     = proto_errs;
    assign instr_answered_o = answered[0];
    assign data_answered_o  = answered[1];

endmodule

// ==== src/processorci_top.sv ====
`include "processorci_consts.svh"

module processorci_top (
    input  logic                      sys_clk,    // System clock
    input  logic                      rst_n_i,

    // Instruction fetch port (OBI)
    input  logic                      instr_req_i,
    input  processorci_pkg::bus_req_t instr_req_data_i,
    output logic                      instr_gnt_o,
    output logic                      instr_rvalid_o,
    output processorci_pkg::data_t    instr_rdata_o,

    // Data port (OBI)
    input  logic                      data_req_i,
    input  processorci_pkg::bus_req_t data_req_data_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output processorci_pkg::data_t    data_rdata_o,

    // Wishbone classic master towards memory
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output processorci_pkg::bus_req_t wb_req_o,
    input  logic                      wb_ack_i,
    input  processorci_pkg::data_t    wb_rdata_i
);

    logic [`NUM_PORTS-1:0]                     pend;
    logic [`NUM_PORTS-1:0]                     done;
    processorci_pkg::bus_req_t [`NUM_PORTS-1:0] held_req;

    // Port 0, instruction fetch
    obi_port u_instr_port (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .req_i       (instr_req_i),
        .req_data_i  (instr_req_data_i),
        .gnt_o       (instr_gnt_o),
        .rvalid_o    (instr_rvalid_o),
        .rdata_o     (instr_rdata_o),
        .pend_o      (pend[0]),
        .held_req_o  (held_req[0]),
        .done_i      (done[0]),
        .bus_rdata_i (wb_rdata_i)     // Read data shared by both ports
    );

    // Port 1, loads and stores
    obi_port u_data_port (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .req_i       (data_req_i),
        .req_data_i  (data_req_data_i),
        .gnt_o       (data_gnt_o),
        .rvalid_o    (data_rvalid_o),
        .rdata_o     (data_rdata_o),
        .pend_o      (pend[1]),
        .held_req_o  (held_req[1]),
        .done_i      (done[1]),
        .bus_rdata_i (wb_rdata_i)
    );

    wb_arbiter u_arbiter (
        .sys_clk  (sys_clk),
        .rst_n_i  (rst_n_i),
        .pend_i   (pend),
        .req_i    (held_req),
        .done_o   (done),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_req_o (wb_req_o),
        .wb_ack_i (wb_ack_i)
    );

endmodule

// ==== src/wb_arbiter.sv ====
`include "processorci_consts.svh"

module wb_arbiter (
    input  logic                      sys_clk,
    input  logic                      rst_n_i,

    // From the OBI ports
    input  logic [`NUM_PORTS-1:0]     pend_i,
    input  processorci_pkg::bus_req_t [`NUM_PORTS-1:0] req_i,
    output logic [`NUM_PORTS-1:0]     done_o,

    // Wishbone classic master
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output processorci_pkg::bus_req_t wb_req_o,
    input  logic                      wb_ack_i
);

    processorci_pkg::arb_state_e state_q;
    processorci_pkg::arb_state_e state_d;
    processorci_pkg::port_idx_t  owner_q;   // Port that owns the current cycle
    processorci_pkg::port_idx_t  last_q;    // Port served by the previous cycle
    processorci_pkg::port_idx_t  pick;
    processorci_pkg::bus_req_t   wb_req_q;
    logic                        start;
    logic                        finish;

    // Round-robin pick, only a tie looks at the pointer
    always_comb begin
        if (&pend_i) begin
            pick = ~last_q;
        end else if (pend_i[1]) begin
            pick = processorci_pkg::port_idx_t'(1);
        end else begin
            pick = processorci_pkg::port_idx_t'(0);
        end
    end

    assign start  = (state_q == processorci_pkg::ARB_IDLE) && (|pend_i);
    assign finish = (state_q == processorci_pkg::ARB_BUS) && wb_ack_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            processorci_pkg::ARB_IDLE: begin
                if (start) begin
                    state_d = processorci_pkg::ARB_BUS;
                end
            end
            processorci_pkg::ARB_BUS: begin
                // Back to idle forces one low cycle of cyc
                if (wb_ack_i) begin
                    state_d = processorci_pkg::ARB_IDLE;
                end
            end
            default: state_d = processorci_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            state_q <= processorci_pkg::ARB_IDLE;
            owner_q <= processorci_pkg::port_idx_t'(0);
            last_q  <= processorci_pkg::port_idx_t'(1);    // First tie goes to instr
        end else begin
            state_q <= state_d;
            if (start) begin
                owner_q <= pick;
            end
            if (finish) begin
                last_q <= owner_q;
            end
        end
    end

    // Bus fields stay frozen for the whole cycle
    always_ff @(posedge sys_clk) begin
        if (start) begin
            wb_req_q <= req_i[pick];
        end
    end

    // Acknowledge routed back to the owner in the ack cycle
    always_comb begin
        done_o = '0;
        if (finish) begin
            done_o[owner_q] = 1'b1;
        end
    end

    assign wb_cyc_o = (state_q == processorci_pkg::ARB_BUS);
    assign wb_stb_o = (state_q == processorci_pkg::ARB_BUS);   // Classic mode, stb follows cyc
    assign wb_req_o = wb_req_q;

endmodule

// ==== src/obi_port.sv ====
module obi_port (
    input  logic                     sys_clk,
    input  logic                     rst_n_i,

    // OBI slave side, driven by the core
    input  logic                     req_i,
    input  processorci_pkg::bus_req_t req_data_i,
    output logic                     gnt_o,
    output logic                     rvalid_o,
    output processorci_pkg::data_t   rdata_o,

    // Towards the arbiter
    output logic                     pend_o,
    output processorci_pkg::bus_req_t held_req_o,
    input  logic                     done_i,
    input  processorci_pkg::data_t   bus_rdata_i
);

    logic                      busy_q;      // Holding register occupied
    logic                      rvalid_q;
    logic                      accept;
    processorci_pkg::bus_req_t held_q;
    processorci_pkg::data_t    rdata_q;

    // Only one outstanding request per port
    assign gnt_o  = req_i & ~busy_q;
    assign accept = req_i & ~busy_q;

    // Busy from the cycle after grant until the rvalid cycle.
    // Clearing it on done lets a new grant land together with rvalid.
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= done_i;             // Response one cycle after ack
            if (done_i) begin
                busy_q <= 1'b0;
            end else if (accept) begin
                busy_q <= 1'b1;
            end
        end
    end

    // Request fields, captured at grant
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            held_q <= req_data_i;
        end
    end

    // Read data from the shared bus, only meaningful on our own done
    always_ff @(posedge sys_clk) begin
        if (done_i) begin
            rdata_q <= bus_rdata_i;     // Undefined for writes
        end
    end

    assign pend_o     = busy_q;
    assign held_req_o = held_q;
    assign rvalid_o   = rvalid_q;
    assign rdata_o    = rdata_q;

endmodule

// ==== src/processorci_pkg.sv ====
`include "processorci_consts.svh"

package processorci_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [`ADDR_WIDTH-1:0]         addr_t;
    typedef logic [`DATA_WIDTH-1:0]         data_t;
    typedef logic [`SEL_WIDTH-1:0]          sel_t;
    typedef logic [$clog2(`NUM_PORTS)-1:0]  port_idx_t;   // 0 = instr, 1 = data

    // One bus request, as taken from OBI and as driven on Wishbone
    typedef struct packed {
        addr_t addr;    // Byte address
        logic  we;      // 1 = write, 0 = read
        sel_t  sel;     // Byte enables
        data_t wdata;   // Write data, ignored on reads
    } bus_req_t;

    // Wishbone cycle sequencer
    typedef enum logic {
        ARB_IDLE,   // Bus free, looking for a pending port
        ARB_BUS     // cyc/stb up, waiting for ack
    } arb_state_e;

endpackage

// ==== src/processorci_consts.svh ====
`ifndef PROCESSORCI_CONSTS_SVH
`define PROCESSORCI_CONSTS_SVH

// Bus widths shared by the OBI ports and the Wishbone side
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define SEL_WIDTH  (`DATA_WIDTH/8)   // One select per byte lane

// Instruction port plus data port
`define NUM_PORTS  2

// Reset fetch address of the core
`define BOOT_ADDR  32'h0000_0000

`endif
